// File: src/vic_load_consts.svh
/*
 * download path constants
 *   file-type codes seen on the index
 *   address limits for programs and cartridges
 *   expansion block count
 *   BASIC pointer locations written after a program load
 */
`ifndef VIC_LOAD_CONSTS_SVH
`define VIC_LOAD_CONSTS_SVH

////////////////////////////////////////
// file-type codes
////////////////////////////////////////
`define IDX_PRG 8'h01
`define IDX_CRT 8'h41
`define IDX_CT  8'h81

////////////////////////////////////////
// address limits, first address not written
////////////////////////////////////////
`define PRG_LIMIT  16'hA000
`define CART_LIMIT 16'hC000

// blocks at 0x0000, 0x2000, 0x4000, 0x6000 and 0xA000
`define NUM_BLKS 5

////////////////////////////////////////
// BASIC pointers, low byte on even entries
////////////////////////////////////////
`define PTR_ADDR_0 16'h002D
`define PTR_ADDR_1 16'h002E
`define PTR_ADDR_2 16'h002F
`define PTR_ADDR_3 16'h0030
`define PTR_ADDR_4 16'h0031
`define PTR_ADDR_5 16'h0032
`define PTR_ADDR_6 16'h00AE
`define PTR_ADDR_7 16'h00AF

`endif

// File: src/vic_load_pkg.sv
/*
 * shared types of the download path
 *   byte and address words
 *   expansion block map
 *   load address union, whole address or 8 KB block plus offset
 */
`include "vic_load_consts.svh"

package vic_load_pkg;

	// one byte of the download stream or of a memory write
	typedef logic [7:0] byte_t;

	// machine address
	typedef logic [15:0] addr_t;

	// bits 0..3 are the blocks at 0x0000..0x6000, bit 4 is 0xA000
	typedef logic [`NUM_BLKS-1:0] blk_map_t;

	// address split on the 8 KB grid
	typedef struct packed {
		logic [2:0]  blk;
		logic [12:0] ofs;
	} blk_addr_t;

	// load address, read whole for the write or split for the block record
	typedef union packed {
		addr_t     addr;
		blk_addr_t split;
	} load_addr_u;

endpackage

// File: src/prg_loader.sv
/*
 * PRG program loader
 *   two header bytes give the load address
 *   payload written upward, cut off at the program limit
 *   eight BASIC end pointers written after the download ends
 */
`include "vic_load_consts.svh"

module prg_loader (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                i_download,
	input  vic_load_pkg::byte_t i_index,
	input  logic                i_dl_valid,
	output logic                o_dl_ready,
	input  vic_load_pkg::byte_t i_dl_data,
	output logic                o_wr_valid,
	input  logic                i_wr_ready,
	output vic_load_pkg::addr_t o_wr_addr,
	output vic_load_pkg::byte_t o_wr_data
);
	import vic_load_pkg::*;

	logic       sel;
	logic       old_download;
	// 0 and 1 are the header bytes, 2 is payload
	logic [1:0] hdr_cnt;
	load_addr_u cur_addr;
	logic       ptr_busy;
	logic [2:0] ptr_idx;
	addr_t      ptr_addr;
	logic       slot_free;
	logic       dl_take;

	assign sel = (i_index == `IDX_PRG);

	// the write slot is free when empty or drained this cycle
	assign slot_free = ~o_wr_valid | i_wr_ready;

	// not selected, so every byte is swallowed
	// pointer phase owns the slot until the last pointer is out
	assign o_dl_ready = ~sel | (~ptr_busy & slot_free);
	assign dl_take = i_download & sel & i_dl_valid & o_dl_ready;

	// pointer location table
	always_comb begin
		case (ptr_idx)
			3'd0: ptr_addr = `PTR_ADDR_0;
			3'd1: ptr_addr = `PTR_ADDR_1;
			3'd2: ptr_addr = `PTR_ADDR_2;
			3'd3: ptr_addr = `PTR_ADDR_3;
			3'd4: ptr_addr = `PTR_ADDR_4;
			3'd5: ptr_addr = `PTR_ADDR_5;
			3'd6: ptr_addr = `PTR_ADDR_6;
			default: ptr_addr = `PTR_ADDR_7;
		endcase
	end

	////////////////////////////////////////
	// control state
	////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
			hdr_cnt <= 2'd0;
			ptr_busy <= 1'b0;
			ptr_idx <= 3'd0;
			o_wr_valid <= 1'b0;
		end else begin
			old_download <= i_download;
			// write taken downstream
			if (o_wr_valid && i_wr_ready) begin
				o_wr_valid <= 1'b0;
			end
			// header position restarts with every file
			if (!i_download) begin
				hdr_cnt <= 2'd0;
			end else if (dl_take && hdr_cnt != 2'd2) begin
				hdr_cnt <= hdr_cnt + 2'd1;
			end
			// payload below the limit becomes a write
			if (dl_take && hdr_cnt == 2'd2 && cur_addr.addr < `PRG_LIMIT) begin
				o_wr_valid <= 1'b1;
			end
			// end of a program file starts the pointer walk
			if (old_download && !i_download && sel) begin
				ptr_busy <= 1'b1;
				ptr_idx <= 3'd0;
			end
			// one pointer per free slot
			if (ptr_busy && slot_free) begin
				o_wr_valid <= 1'b1;
				ptr_idx <= ptr_idx + 3'd1;
				if (ptr_idx == 3'd7) begin
					ptr_busy <= 1'b0;
				end
			end
		end
	end

	////////////////////////////////////////
	// address and write payload
	////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (dl_take) begin
			case (hdr_cnt)
				2'd0: cur_addr.addr[7:0] <= i_dl_data;
				2'd1: cur_addr.addr[15:8] <= i_dl_data;
				default: begin
					// above the limit the byte is dropped and the address holds
					if (cur_addr.addr < `PRG_LIMIT) begin
						o_wr_addr <= cur_addr.addr;
						o_wr_data <= i_dl_data;
						cur_addr.addr <= cur_addr.addr + 16'd1;
					end
				end
			endcase
		end
		// end address, low byte on even entries
		if (ptr_busy && slot_free) begin
			o_wr_addr <= ptr_addr;
			o_wr_data <= ptr_idx[0] ? cur_addr.addr[15:8] : cur_addr.addr[7:0];
		end
	end

endmodule

// File: src/cart_loader.sv
/*
 * cartridge loader for CRT and CT files
 *   CRT load address from the two header bytes
 *   CT load address from the file-extension character
 *   payload cut off at the cartridge limit
 *   record of every 8 KB block written, cleared on detach
 */
`include "vic_load_consts.svh"

module cart_loader (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   i_download,
	input  vic_load_pkg::byte_t    i_index,
	input  vic_load_pkg::byte_t    i_file_ext,
	input  logic                   i_detach,
	input  logic                   i_dl_valid,
	output logic                   o_dl_ready,
	input  vic_load_pkg::byte_t    i_dl_data,
	output logic                   o_wr_valid,
	input  logic                   i_wr_ready,
	output vic_load_pkg::addr_t    o_wr_addr,
	output vic_load_pkg::byte_t    o_wr_data,
	output vic_load_pkg::blk_map_t o_cart_blk
);
	import vic_load_pkg::*;

	logic       sel_crt;
	logic       sel_ct;
	// 0 and 1 are CRT header bytes, 2 is payload
	logic [1:0] hdr_cnt;
	load_addr_u cur_addr;
	// address of the byte on the stream this cycle
	load_addr_u pos;
	addr_t      ext_addr;
	blk_map_t   blk_hit;
	logic       dl_take;
	logic       payload;
	logic       in_range;

	assign sel_crt = (i_index == `IDX_CRT);
	assign sel_ct = (i_index == `IDX_CT);

	// other file types pass straight through
	assign o_dl_ready = ~(sel_crt | sel_ct) | ~o_wr_valid | i_wr_ready;
	assign dl_take = i_download & (sel_crt | sel_ct) & i_dl_valid & o_dl_ready;

	// extension digit 2..9 is that many 4 KB pages, A and B are 0xA000 and 0xB000
	always_comb begin
		if (i_file_ext >= "2" && i_file_ext <= "9") begin
			ext_addr = {i_file_ext[3:0], 12'h000};
		end else if (i_file_ext == "A" || i_file_ext == "B") begin
			ext_addr = {i_file_ext[3:0] + 4'd9, 12'h000};
		end else begin
			ext_addr = 16'h0000;
		end
	end

	// first CT byte goes to the extension address
	always_comb begin
		pos = cur_addr;
		if (sel_ct && hdr_cnt == 2'd0) begin
			pos.addr = ext_addr;
		end
	end

	assign payload = dl_take & (sel_ct | (hdr_cnt == 2'd2));
	assign in_range = (pos.addr < `CART_LIMIT);

	// block number 4 is the I/O and ROM area, nothing is recorded
	always_comb begin
		blk_hit = '0;
		case (pos.split.blk)
			3'd0: blk_hit[0] = 1'b1;
			3'd1: blk_hit[1] = 1'b1;
			3'd2: blk_hit[2] = 1'b1;
			3'd3: blk_hit[3] = 1'b1;
			3'd5: blk_hit[4] = 1'b1;
			default: ;
		endcase
	end

	////////////////////////////////////////
	// control state and block record
	////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hdr_cnt <= 2'd0;
			o_wr_valid <= 1'b0;
			o_cart_blk <= '0;
		end else begin
			if (o_wr_valid && i_wr_ready) begin
				o_wr_valid <= 1'b0;
			end
			// ct has no header, it jumps to payload on the first byte
			if (!i_download) begin
				hdr_cnt <= 2'd0;
			end else if (dl_take && sel_ct) begin
				hdr_cnt <= 2'd2;
			end else if (dl_take && hdr_cnt != 2'd2) begin
				hdr_cnt <= hdr_cnt + 2'd1;
			end
			if (payload && in_range) begin
				o_wr_valid <= 1'b1;
			end
			// detach wins over a write in the same cycle
			if (i_detach) begin
				o_cart_blk <= '0;
			end else if (payload && in_range) begin
				o_cart_blk <= o_cart_blk | blk_hit;
			end
		end
	end

	////////////////////////////////////////
	// address and write payload
	////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (dl_take && !payload) begin
			if (hdr_cnt == 2'd0) begin
				cur_addr.addr[7:0] <= i_dl_data;
			end else begin
				cur_addr.addr[15:8] <= i_dl_data;
			end
		end
		// bytes past the limit are dropped and the address holds
		if (payload && in_range) begin
			o_wr_addr <= pos.addr;
			o_wr_data <= i_dl_data;
			cur_addr.addr <= pos.addr + 16'd1;
		end
	end

endmodule

// File: src/load_write_merge.sv
/*
 * write merge stage
 *   combined download ready of both loaders
 *   one registered write port, program side first
 *   registered RAM-expansion maps from the block record
 */
`include "vic_load_consts.svh"

module load_write_merge (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   i_prg_ready,
	input  logic                   i_cart_ready,
	output logic                   o_dl_ready,
	input  logic                   i_prg_wr_valid,
	output logic                   o_prg_wr_ready,
	input  vic_load_pkg::addr_t    i_prg_wr_addr,
	input  vic_load_pkg::byte_t    i_prg_wr_data,
	input  logic                   i_cart_wr_valid,
	output logic                   o_cart_wr_ready,
	input  vic_load_pkg::addr_t    i_cart_wr_addr,
	input  vic_load_pkg::byte_t    i_cart_wr_data,
	input  vic_load_pkg::blk_map_t i_cart_blk,
	input  vic_load_pkg::blk_map_t i_extram,
	input  logic                   i_cart_writable,
	output logic                   o_wr_valid,
	input  logic                   i_wr_ready,
	output vic_load_pkg::addr_t    o_wr_addr,
	output vic_load_pkg::byte_t    o_wr_data,
	output vic_load_pkg::blk_map_t o_ram_ext,
	output vic_load_pkg::blk_map_t o_ram_ext_ro
);
	logic slot_free;

	// the unselected loader always reports ready, so the selected one decides
	assign o_dl_ready = i_prg_ready & i_cart_ready;

	// output register empty or drained this cycle
	assign slot_free = ~o_wr_valid | i_wr_ready;

	// program side has priority, cart waits while it has a write
	assign o_prg_wr_ready = slot_free;
	assign o_cart_wr_ready = slot_free & ~i_prg_wr_valid;

	////////////////////////////////////////
	// output write register
	////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			o_wr_valid <= 1'b0;
		end else if (slot_free) begin
			o_wr_valid <= i_prg_wr_valid | i_cart_wr_valid;
		end
	end

	// address and data hold while the port stalls
	always_ff @(posedge clk_sys) begin
		if (slot_free && i_prg_wr_valid) begin
			o_wr_addr <= i_prg_wr_addr;
			o_wr_data <= i_prg_wr_data;
		end else if (slot_free && i_cart_wr_valid) begin
			o_wr_addr <= i_cart_wr_addr;
			o_wr_data <= i_cart_wr_data;
		end
	end

	////////////////////////////////////////
	// RAM-expansion maps
	////////////////////////////////////////
	// cartridge blocks are present and read only unless marked writable
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			o_ram_ext <= '0;
			o_ram_ext_ro <= '0;
		end else begin
			o_ram_ext <= i_extram | i_cart_blk;
			o_ram_ext_ro <= i_cart_writable ? {`NUM_BLKS{1'b0}} : i_cart_blk;
		end
	end

endmodule

// File: src/vic_loader_top.sv
/*
 * download path top level
 *   stream fans out to the program and cartridge loaders
 *   merge stage forms the write port and expansion maps
 */

module vic_loader_top (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   i_download,
	input  vic_load_pkg::byte_t    i_index,
	input  vic_load_pkg::byte_t    i_file_ext,
	input  logic                   i_dl_valid,
	output logic                   o_dl_ready,
	input  vic_load_pkg::byte_t    i_dl_data,
	input  vic_load_pkg::blk_map_t i_extram,
	input  logic                   i_cart_writable,
	input  logic                   i_detach,
	output logic                   o_wr_valid,
	input  logic                   i_wr_ready,
	output vic_load_pkg::addr_t    o_wr_addr,
	output vic_load_pkg::byte_t    o_wr_data,
	output vic_load_pkg::blk_map_t o_ram_ext,
	output vic_load_pkg::blk_map_t o_ram_ext_ro
);
	import vic_load_pkg::*;

	// download readies of the two loaders
	logic     prg_dl_ready;
	logic     cart_dl_ready;

	// program loader write port
	logic     prg_wr_valid;
	logic     prg_wr_ready;
	addr_t    prg_wr_addr;
	byte_t    prg_wr_data;

	// cartridge loader write port and block record
	logic     cart_wr_valid;
	logic     cart_wr_ready;
	addr_t    cart_wr_addr;
	byte_t    cart_wr_data;
	blk_map_t cart_blk;

	prg_loader prg_loader_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.i_download (i_download),
		.i_index    (i_index),
		.i_dl_valid (i_dl_valid),
		.o_dl_ready (prg_dl_ready),
		.i_dl_data  (i_dl_data),
		.o_wr_valid (prg_wr_valid),
		.i_wr_ready (prg_wr_ready),
		.o_wr_addr  (prg_wr_addr),
		.o_wr_data  (prg_wr_data)
	);

	cart_loader cart_loader_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.i_download (i_download),
		.i_index    (i_index),
		.i_file_ext (i_file_ext),
		.i_detach   (i_detach),
		.i_dl_valid (i_dl_valid),
		.o_dl_ready (cart_dl_ready),
		.i_dl_data  (i_dl_data),
		.o_wr_valid (cart_wr_valid),
		.i_wr_ready (cart_wr_ready),
		.o_wr_addr  (cart_wr_addr),
		.o_wr_data  (cart_wr_data),
		.o_cart_blk (cart_blk)
	);

	load_write_merge merge_i (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.i_prg_ready     (prg_dl_ready),
		.i_cart_ready    (cart_dl_ready),
		.o_dl_ready      (o_dl_ready),
		.i_prg_wr_valid  (prg_wr_valid),
		.o_prg_wr_ready  (prg_wr_ready),
		.i_prg_wr_addr   (prg_wr_addr),
		.i_prg_wr_data   (prg_wr_data),
		.i_cart_wr_valid (cart_wr_valid),
		.o_cart_wr_ready (cart_wr_ready),
		.i_cart_wr_addr  (cart_wr_addr),
		.i_cart_wr_data  (cart_wr_data),
		.i_cart_blk      (cart_blk),
		.i_extram        (i_extram),
		.i_cart_writable (i_cart_writable),
		.o_wr_valid      (o_wr_valid),
		.i_wr_ready      (i_wr_ready),
		.o_wr_addr       (o_wr_addr),
		.o_wr_data       (o_wr_data),
		.o_ram_ext       (o_ram_ext),
		.o_ram_ext_ro    (o_ram_ext_ro)
	);

endmodule

// File: verification/vic_loader_assertions.sv
/*
 * bound checks on the download path top level
 *   write address and data hold while the port stalls
 *   read-only map within the expansion map
 *   no write pending right after reset
 */

module vic_loader_assertions (
	input logic                   clk_sys,
	input logic                   reset,
	input logic                   i_wr_valid,
	input logic                   i_wr_ready,
	input vic_load_pkg::addr_t    i_wr_addr,
	input vic_load_pkg::byte_t    i_wr_data,
	input vic_load_pkg::blk_map_t i_ram_ext,
	input vic_load_pkg::blk_map_t i_ram_ext_ro
);

	////////////////////////////////////////
	// write port
	////////////////////////////////////////
	// a stalled write keeps its address and data
	wr_hold_a: assert property (@(posedge clk_sys) disable iff (reset)
		(i_wr_valid && !i_wr_ready) |=> ($stable(i_wr_addr) && $stable(i_wr_data)))
		else $error("write address or data changed during a stall");

	wr_reset_a: assert property (@(posedge clk_sys) reset |=> !i_wr_valid)
		else $error("write valid high after reset");

	////////////////////////////////////////
	// expansion maps
	////////////////////////////////////////
	// every read-only block is also present
	ro_subset_a: assert property (@(posedge clk_sys) disable iff (reset)
		(i_ram_ext_ro & ~i_ram_ext) == '0)
		else $error("read-only map has a block outside the expansion map");

endmodule

bind vic_loader_top vic_loader_assertions assertions_i (
	.clk_sys      (clk_sys),
	.reset        (reset),
	.i_wr_valid   (o_wr_valid),
	.i_wr_ready   (i_wr_ready),
	.i_wr_addr    (o_wr_addr),
	.i_wr_data    (o_wr_data),
	.i_ram_ext    (o_ram_ext),
	.i_ram_ext_ro (o_ram_ext_ro)
);

// File: verification/vic_loader_tb.sv
/*
 * testbench for the download path top level
 *   clock, reset and stimulus at a fixed delay after the rising edge
 *   Galois LFSR for payload bytes, valid gaps and write stalls
 *   reference model of the expected writes and block record
 *   comparison of every output write, watchdog and summary
 */
`include "vic_load_consts.svh"

module vic_loader_tb;
	import vic_load_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DLY = 2;
	localparam int READY_WAIT = 100;
	localparam int DRAIN_WAIT = 200;

	// payload lengths of the tests
	localparam int N_PRG = 64;
	localparam int N_TRUNC = 40;
	localparam int N_CRT = 9216;
	localparam int N_CT_A = 8208;
	localparam int N_CT_2 = 64;
	localparam int N_STALL_PRG = 300;
	localparam int N_STALL_CRT = 200;
	// headers, pointer writes, reset and settling on top of the payload
	localparam int STREAM_LEN = N_PRG + N_TRUNC + N_CRT + N_CT_A + N_CT_2 + N_STALL_PRG
		+ N_STALL_CRT + 10 + 24 + 200;
	localparam int STALL_FACTOR = 4;
	localparam longint WATCHDOG_TIME = longint'(STREAM_LEN) * STALL_FACTOR * CLK_PERIOD;

	logic     clk_sys;
	logic     reset;
	logic     i_download;
	byte_t    i_index;
	byte_t    i_file_ext;
	logic     i_dl_valid;
	logic     o_dl_ready;
	byte_t    i_dl_data;
	blk_map_t i_extram;
	logic     i_cart_writable;
	logic     i_detach;
	logic     o_wr_valid;
	logic     i_wr_ready;
	addr_t    o_wr_addr;
	byte_t    o_wr_data;
	blk_map_t o_ram_ext;
	blk_map_t o_ram_ext_ro;

	// expected writes as {address, data}
	logic [23:0] exp_q[$];
	logic [23:0] got_exp;
	blk_map_t    exp_blk;
	logic [15:0] stim_seed;
	logic [15:0] stall_seed;
	logic        stall_en;
	string       test_name;
	int          err_cnt;
	int          test_err;
	int          test_cnt;
	int          wr_cnt;

	vic_loader_top dut_i (.*);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	////////////////////////////////////////
	// random source
	////////////////////////////////////////
	// right-shift Galois form, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic logic take_bit();
		logic b;
		b = stim_seed[0];
		stim_seed = lfsr_step(stim_seed);
		return b;
	endfunction

	function automatic byte_t take_byte();
		byte_t v;
		int    i;
		v = '0;
		for (i = 0; i < 8; i++) begin
			v = {v[6:0], take_bit()};
		end
		return v;
	endfunction

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////
	// ct start address, digit times 4 KB or the A and B banks
	function automatic addr_t ct_start(input byte_t ext);
		if (ext >= "2" && ext <= "9") begin
			return 16'(ext - "0") * 16'd4096;
		end else if (ext == "A") begin
			return 16'hA000;
		end else if (ext == "B") begin
			return 16'hB000;
		end
		return 16'h0000;
	endfunction

	// 8 KB block to map bit, block 4 is not an expansion block
	function automatic blk_map_t blk_bit(input addr_t a);
		blk_map_t m;
		m = '0;
		case (a >> 13)
			16'd0: m[0] = 1'b1;
			16'd1: m[1] = 1'b1;
			16'd2: m[2] = 1'b1;
			16'd3: m[3] = 1'b1;
			16'd5: m[4] = 1'b1;
			default: m = '0;
		endcase
		return m;
	endfunction

	// {hit, address, data} for stream position pos
	// positions past the payload are the eight pointer writes of a program
	function automatic logic [24:0] ref_write(input byte_t kind, input addr_t start,
			input int pos, input int n_bytes, input byte_t data);
		int    lim;
		int    a;
		int    end_a;
		int    k;
		addr_t ptr;
		lim = (kind == `IDX_PRG) ? int'(`PRG_LIMIT) : int'(`CART_LIMIT);
		a = int'(start) + pos;
		if (pos < n_bytes) begin
			return {(a < lim), a[15:0], data};
		end
		// end address is the first one not written
		if (int'(start) >= lim) begin
			end_a = int'(start);
		end else begin
			end_a = (int'(start) + n_bytes < lim) ? int'(start) + n_bytes : lim;
		end
		k = pos - n_bytes;
		case (k)
			0: ptr = `PTR_ADDR_0;
			1: ptr = `PTR_ADDR_1;
			2: ptr = `PTR_ADDR_2;
			3: ptr = `PTR_ADDR_3;
			4: ptr = `PTR_ADDR_4;
			5: ptr = `PTR_ADDR_5;
			6: ptr = `PTR_ADDR_6;
			default: ptr = `PTR_ADDR_7;
		endcase
		return {1'b1, ptr, k[0] ? end_a[15:8] : end_a[7:0]};
	endfunction

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////
	task automatic note_error();
		err_cnt++;
		test_err++;
	endtask

	task automatic next_drive();
		@(posedge clk_sys);
		#DRIVE_DLY;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_err = 0;
		wr_cnt = 0;
	endtask

	task automatic finish_test();
		test_cnt++;
		$display("test %s done, %0d writes checked, %0d errors", test_name, wr_cnt, test_err);
	endtask

	// one stream byte, with random gaps while stalls are on
	task automatic send_byte(input byte_t b);
		int waited;
		waited = 0;
		while (stall_en && take_bit()) begin
			i_dl_valid = 1'b0;
			next_drive();
		end
		i_dl_valid = 1'b1;
		i_dl_data = b;
		// ready is settled by the falling edge
		@(negedge clk_sys);
		while (!o_dl_ready && waited < READY_WAIT) begin
			waited++;
			@(negedge clk_sys);
		end
		assert (o_dl_ready) else begin
			$display("o_dl_ready stayed low for %0d cycles in test %s", waited, test_name);
			note_error();
		end
		next_drive();
		i_dl_valid = 1'b0;
	endtask

	task automatic check_maps();
		blk_map_t want_ro;
		repeat (3) next_drive();
		want_ro = i_cart_writable ? blk_map_t'(0) : exp_blk;
		assert (o_ram_ext == (i_extram | exp_blk)) else begin
			$display("error %s o_ram_ext: expected %h, actual %h", test_name,
				i_extram | exp_blk, o_ram_ext);
			note_error();
		end
		assert (o_ram_ext_ro == want_ro) else begin
			$display("error %s o_ram_ext_ro: expected %h, actual %h", test_name,
				want_ro, o_ram_ext_ro);
			note_error();
		end
	endtask

	// one file download, expected writes queued before the stream starts
	task automatic run_load(input string name, input byte_t kind, input byte_t ext,
			input addr_t hdr, input int n_bytes);
		addr_t       start;
		byte_t       pay[$];
		logic [24:0] w;
		int          n_pos;
		int          i;
		int          waited;
		start_test(name);
		start = (kind == `IDX_CT) ? ct_start(ext) : hdr;
		for (i = 0; i < n_bytes; i++) begin
			pay.push_back(take_byte());
		end
		n_pos = n_bytes + ((kind == `IDX_PRG) ? 8 : 0);
		for (i = 0; i < n_pos; i++) begin
			w = ref_write(kind, start, i, n_bytes, (i < n_bytes) ? pay[i] : 8'h00);
			if (w[24]) begin
				exp_q.push_back(w[23:0]);
				if (kind != `IDX_PRG) begin
					exp_blk = exp_blk | blk_bit(w[23:8]);
				end
			end
		end
		i_index = kind;
		i_file_ext = ext;
		i_download = 1'b1;
		// ct files carry no header
		if (kind != `IDX_CT) begin
			send_byte(hdr[7:0]);
			send_byte(hdr[15:8]);
		end
		for (i = 0; i < n_bytes; i++) begin
			send_byte(pay[i]);
		end
		i_download = 1'b0;
		waited = 0;
		while (exp_q.size() != 0 && waited < DRAIN_WAIT) begin
			waited++;
			next_drive();
		end
		assert (exp_q.size() == 0) else begin
			$display("%0d writes never appeared in test %s", exp_q.size(), test_name);
			note_error();
			exp_q.delete();
		end
		// a stray extra write would show here
		check_maps();
	endtask

	////////////////////////////////////////
	// write port stalls and comparison
	////////////////////////////////////////
	always @(posedge clk_sys) begin
		#DRIVE_DLY;
		if (stall_en) begin
			i_wr_ready = stall_seed[0];
			stall_seed = lfsr_step(stall_seed);
		end else begin
			i_wr_ready = 1'b1;
		end
	end

	// handshake seen at the falling edge is taken on the next rising edge
	always @(negedge clk_sys) begin
		if (!reset && o_wr_valid && i_wr_ready) begin
			assert (exp_q.size() != 0) else begin
				$display("unexpected write to %h in test %s", o_wr_addr, test_name);
				note_error();
			end
			if (exp_q.size() != 0) begin
				got_exp = exp_q.pop_front();
				wr_cnt++;
				assert (o_wr_addr == got_exp[23:8]) else begin
					$display("error %s address: expected %h, actual %h", test_name,
						got_exp[23:8], o_wr_addr);
					note_error();
				end
				assert (o_wr_data == got_exp[7:0]) else begin
					$display("error %s data at %h: expected %h, actual %h", test_name,
						got_exp[23:8], got_exp[7:0], o_wr_data);
					note_error();
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("watchdog expired at %0t, the run did not finish", $time);
		$display("Errors found");
		$finish;
	end

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////
	initial begin
		clk_sys = 1'b0;
		reset = 1'b1;
		i_download = 1'b0;
		i_index = 8'h00;
		i_file_ext = 8'h00;
		i_dl_valid = 1'b0;
		i_dl_data = 8'h00;
		i_extram = 5'b00001;
		i_cart_writable = 1'b0;
		i_detach = 1'b0;
		i_wr_ready = 1'b1;
		stim_seed = 16'd65156;
		stall_seed = 16'd65156;
		stall_en = 1'b0;
		exp_blk = '0;
		err_cnt = 0;
		test_cnt = 0;
		repeat (10) @(posedge clk_sys);
		#DRIVE_DLY;
		reset = 1'b0;
		next_drive();

		run_load("prg_load", `IDX_PRG, 8'h00, 16'h1001, N_PRG);
		finish_test();
		run_load("prg_trunc", `IDX_PRG, 8'h00, 16'h9FF0, N_TRUNC);
		finish_test();
		run_load("crt_load", `IDX_CRT, 8'h00, 16'h6000, N_CRT);
		// read-only map follows the writable switch
		i_cart_writable = 1'b1;
		check_maps();
		i_cart_writable = 1'b0;
		check_maps();
		finish_test();
		run_load("ct_ext_a", `IDX_CT, "A", 16'h0000, N_CT_A);
		finish_test();
		run_load("ct_ext_2", `IDX_CT, "2", 16'h0000, N_CT_2);
		finish_test();

		@(negedge clk_sys);
		stall_en = 1'b1;
		next_drive();
		run_load("stall_prg", `IDX_PRG, 8'h00, 16'h0400, N_STALL_PRG);
		finish_test();
		run_load("stall_crt", `IDX_CRT, 8'h00, 16'h4000, N_STALL_CRT);
		finish_test();
		@(negedge clk_sys);
		stall_en = 1'b0;
		next_drive();

		// detach empties the record
		start_test("detach");
		i_detach = 1'b1;
		next_drive();
		i_detach = 1'b0;
		exp_blk = '0;
		check_maps();
		finish_test();

		$display("%0d tests run, %0d errors", test_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// File: verilog.f
+incdir+src
src/vic_load_pkg.sv
src/prg_loader.sv
src/cart_loader.sv
src/load_write_merge.sv
src/vic_loader_top.sv
verification/vic_loader_assertions.sv
verification/vic_loader_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the download path testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f verilog.f --top-module vic_loader_tb -o vic_loader_sim
./obj_dir/vic_loader_sim | tee "$LOG"

if grep -q "Errors found" "$LOG"; then
	echo "simulation failed"
	exit 1
fi
if ! grep -q "No errors" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"
